/* include/miner_params.svh */
`ifndef MINER_PARAMS_SVH
`define MINER_PARAMS_SVH

// ----------------------------------------------------------------------
// SHA-256 engine timing
// ----------------------------------------------------------------------

`define MINER_ROUNDS 64        // Rounds per compressed block.
`define MINER_BLOCK_CYCLES 65  // Rounds plus the cycle that carries the digest.

// Four block phases per attempt with the last one idle.
`define MINER_PHASES 4

// ----------------------------------------------------------------------
// Message padding
// ----------------------------------------------------------------------

`define MINER_LEN_BITS 64      // Width of the length field at the block end.
`define MINER_SECOND_LEN 640   // Whole 80-byte header.
`define MINER_FINAL_LEN 256    // First digest rehashed.

`endif

/* rtl/minerPkg.sv */
`include "miner_params.svh"

package minerPkg;

	typedef logic [31:0] word32;
	typedef logic [255:0] digest256;
	typedef logic [511:0] block512;
	typedef logic [639:0] header640;
	typedef logic [6:0] roundIdx;

	// Encoding follows the block order, so a plain increment walks the attempt.
	typedef enum logic [$clog2(`MINER_PHASES)-1:0] {
		phaseFirst  = 0,
		phaseSecond = 1,
		phaseFinal  = 2,
		phaseIdle   = 3
	} blockPhase;

	localparam digest256 shaInit = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	localparam word32 roundConst [0:`MINER_ROUNDS-1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage

/* rtl/sha256Schedule.sv */
`timescale 1ns/1ns

module sha256Schedule import minerPkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    load,
	input  block512 block,
	output word32   roundWord
);

	word32 window [0:15];
	word32 view [0:15];
	word32 newWord;

	function automatic word32 rotr(input word32 x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// On a load the block itself is the window for round 0.
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			view[i] = load ? block[511 - 32*i -: 32] : window[i];
		end
		newWord = (rotr(view[14], 17) ^ rotr(view[14], 19) ^ (view[14] >> 10))
			+ view[9]
			+ (rotr(view[1], 7) ^ rotr(view[1], 18) ^ (view[1] >> 3))
			+ view[0];
		roundWord = view[0];
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 15; i++) begin
			window[i] <= view[i + 1];
		end
		window[15] <= newWord; // W[t+16].
	end

	// A load is a single-cycle strobe.
	loadIsStrobe: assert property (@(posedge clk) disable iff (rst)
		load |=> !load);

endmodule

/* rtl/sha256Core.sv */
`timescale 1ns/1ns
`include "miner_params.svh"

module sha256Core import minerPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     coreStart,
	input  block512  coreBlock,
	input  digest256 coreChain,
	output digest256 coreDigest,
	output logic     coreDone
);

	word32 work [0:7];   // Working words a to h.
	word32 cur [0:7];
	word32 nxt [0:7];
	word32 roundWord;
	word32 t1;
	word32 t2;
	roundIdx rIdx;
	roundIdx kIdx;
	logic busy;
	logic lastRound;

	function automatic word32 rotr(input word32 x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	sha256Schedule schedule (
		.clk       (clk),
		.rst       (rst),
		.load      (coreStart),
		.block     (coreBlock),
		.roundWord (roundWord)
	);

	// ----------------------------------------------------------------------
	// Round datapath
	// ----------------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			cur[i] = coreStart ? coreChain[255 - 32*i -: 32] : work[i];
		end
		kIdx = coreStart ? '0 : rIdx;

		t1 = cur[7]
			+ (rotr(cur[4], 6) ^ rotr(cur[4], 11) ^ rotr(cur[4], 25))
			+ ((cur[4] & cur[5]) ^ (~cur[4] & cur[6]))
			+ roundConst[kIdx[5:0]]
			+ roundWord;
		t2 = (rotr(cur[0], 2) ^ rotr(cur[0], 13) ^ rotr(cur[0], 22))
			+ ((cur[0] & cur[1]) ^ (cur[0] & cur[2]) ^ (cur[1] & cur[2]));

		nxt[0] = t1 + t2;
		nxt[1] = cur[0];
		nxt[2] = cur[1];
		nxt[3] = cur[2];
		nxt[4] = cur[3] + t1;
		nxt[5] = cur[4];
		nxt[6] = cur[5];
		nxt[7] = cur[6];

		lastRound = busy && (rIdx == roundIdx'(`MINER_ROUNDS - 1));
	end

	// ----------------------------------------------------------------------
	// Sequencing
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			rIdx <= '0;
			coreDone <= 1'b0;
		end else begin
			coreDone <= lastRound;
			if (coreStart) begin
				busy <= 1'b1;
				rIdx <= roundIdx'(1); // Round 0 runs in the start cycle.
			end else if (busy) begin
				rIdx <= rIdx + 1'b1;
				if (lastRound)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (coreStart || busy) begin
			for (int i = 0; i < 8; i++) begin
				work[i] <= nxt[i];
			end
		end
		// Feed-forward folded into the last round.
		if (lastRound) begin
			for (int i = 0; i < 8; i++) begin
				coreDigest[255 - 32*i -: 32] <= coreChain[255 - 32*i -: 32] + nxt[i];
			end
		end
	end

	noStartWhileBusy: assert property (@(posedge clk) disable iff (rst)
		coreStart |-> !busy);

	// Digest lands on the last cycle of the block phase.
	doneAfterStart: assert property (@(posedge clk) disable iff (rst)
		coreStart |-> ##(`MINER_ROUNDS) coreDone);

endmodule

/* rtl/minerControl.sv */
`timescale 1ns/1ns
`include "miner_params.svh"

module minerControl import minerPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  header640 blockHeader,
	input  word32    nonce,
	input  digest256 difficulty,
	input  logic     resetButton,
	input  digest256 coreDigest,
	input  logic     coreDone,
	output logic     coreStart,
	output block512  coreBlock,
	output digest256 coreChain,
	output logic     hashSuccess,
	output digest256 satisfactoryHash,
	output logic     ledControl
);

	roundIdx cycleCnt;
	blockPhase phase;
	digest256 midstate;
	digest256 firstDigest;
	digest256 reversed;
	logic phaseEnd;
	logic hit;

	// ----------------------------------------------------------------------
	// Block construction and chaining
	// ----------------------------------------------------------------------

	always_comb begin
		phaseEnd = cycleCnt == roundIdx'(`MINER_BLOCK_CYCLES - 1);
		coreStart = (cycleCnt == '0) && (phase != phaseIdle);

		case (phase)
			phaseFirst: begin
				coreBlock = blockHeader[639:128];
				coreChain = shaInit;
			end
			phaseSecond: begin
				coreBlock = {blockHeader[127:32], nonce, 1'b1, {319{1'b0}},
					`MINER_LEN_BITS'(`MINER_SECOND_LEN)};
				coreChain = midstate; // Continue from block one.
			end
			default: begin
				coreBlock = {firstDigest, 1'b1, {191{1'b0}},
					`MINER_LEN_BITS'(`MINER_FINAL_LEN)};
				coreChain = shaInit;
			end
		endcase
	end

	// ----------------------------------------------------------------------
	// Difficulty check
	// ----------------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < 32; i++) begin
			reversed[8*i +: 8] = coreDigest[8*(31 - i) +: 8];
		end
		hit = reversed < difficulty;
	end

	assign satisfactoryHash = hashSuccess ? coreDigest : '0; // Zero outside the strobe.

	always_ff @(posedge clk) begin
		if (rst) begin
			cycleCnt <= '0;
			phase <= phaseFirst;
			hashSuccess <= 1'b0;
			ledControl <= 1'b0;
		end else begin
			cycleCnt <= phaseEnd ? '0 : cycleCnt + 1'b1;
			if (phaseEnd)
				phase <= blockPhase'(phase + 1'b1); // Idle wraps to first.
			hashSuccess <= coreDone && (phase == phaseFinal) && hit;
			if (resetButton)
				ledControl <= 1'b0;
			else if (hashSuccess)
				ledControl <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (coreDone && phase == phaseFirst)
			midstate <= coreDigest;
		if (coreDone && phase == phaseSecond)
			firstDigest <= coreDigest;
	end

	singleStrobe: assert property (@(posedge clk) disable iff (rst)
		hashSuccess |=> !hashSuccess);

	// The core must finish in step with the phase counter.
	doneAtPhaseEnd: assert property (@(posedge clk) disable iff (rst)
		coreDone |-> phaseEnd);

endmodule

/* rtl/minerTop.sv */
`timescale 1ns/1ns

module minerTop import minerPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     resetButton,
	input  header640 blockHeader,
	input  word32    nonce,
	input  digest256 difficulty,
	output logic     hashSuccess,
	output logic     ledControl,
	output digest256 satisfactoryHash
);

	logic coreStart;
	logic coreDone;
	block512 coreBlock;
	digest256 coreChain;
	digest256 coreDigest;

	minerControl control (
		.clk              (clk),
		.rst              (rst),
		.blockHeader      (blockHeader),
		.nonce            (nonce),
		.difficulty       (difficulty),
		.resetButton      (resetButton),
		.coreDigest       (coreDigest),
		.coreDone         (coreDone),
		.coreStart        (coreStart),
		.coreBlock        (coreBlock),
		.coreChain        (coreChain),
		.hashSuccess      (hashSuccess),
		.satisfactoryHash (satisfactoryHash),
		.ledControl       (ledControl)
	);

	sha256Core core (
		.clk        (clk),
		.rst        (rst),
		.coreStart  (coreStart),
		.coreBlock  (coreBlock),
		.coreChain  (coreChain),
		.coreDigest (coreDigest),
		.coreDone   (coreDone)
	);

endmodule

/* tb/minerTb.sv */
`timescale 1ns/1ns
`include "miner_params.svh"

module minerTb import minerPkg::*; ();

	localparam int clockPeriod = 8;
	localparam int resetCycles = 10;
	localparam int attemptCycles = `MINER_PHASES * `MINER_BLOCK_CYCLES;
	localparam int numAttempts = 9;
	localparam int watchdogCycles = 12 * attemptCycles + resetCycles + 100;
	localparam int strobeCycle = 3 * `MINER_BLOCK_CYCLES; // First idle cycle.
	localparam int applyCycle = 200;
	localparam int buttonCycle = 230;

	localparam digest256 initHash =
		256'h6a09e667bb67ae853c6ef372a54ff53a510e527f9b05688c1f83d9ab5be0cd19;
	localparam word32 refK [0:63] = '{
		'h428a2f98, 'h71374491, 'hb5c0fbcf, 'he9b5dba5,
		'h3956c25b, 'h59f111f1, 'h923f82a4, 'hab1c5ed5,
		'hd807aa98, 'h12835b01, 'h243185be, 'h550c7dc3,
		'h72be5d74, 'h80deb1fe, 'h9bdc06a7, 'hc19bf174,
		'he49b69c1, 'hefbe4786, 'h0fc19dc6, 'h240ca1cc,
		'h2de92c6f, 'h4a7484aa, 'h5cb0a9dc, 'h76f988da,
		'h983e5152, 'ha831c66d, 'hb00327c8, 'hbf597fc7,
		'hc6e00bf3, 'hd5a79147, 'h06ca6351, 'h14292967,
		'h27b70a85, 'h2e1b2138, 'h4d2c6dfc, 'h53380d13,
		'h650a7354, 'h766a0abb, 'h81c2c92e, 'h92722c85,
		'ha2bfe8a1, 'ha81a664b, 'hc24b8b70, 'hc76c51a3,
		'hd192e819, 'hd6990624, 'hf40e3585, 'h106aa070,
		'h19a4c116, 'h1e376c08, 'h2748774c, 'h34b0bcb5,
		'h391c0cb3, 'h4ed8aa4a, 'h5b9cca4f, 'h682e6ff3,
		'h748f82ee, 'h78a5636f, 'h84c87814, 'h8cc70208,
		'h90befffa, 'ha4506ceb, 'hbef9a3f7, 'hc67178f2
	};

	logic clk = 1'b0;
	logic rst;
	logic resetButton;
	header640 blockHeader;
	word32 nonce;
	digest256 difficulty;
	logic hashSuccess;
	logic ledControl;
	digest256 satisfactoryHash;

	header640 hdrTab [numAttempts];
	word32 nonceTab [numAttempts];
	digest256 diffTab [numAttempts];
	digest256 digTab [numAttempts];
	logic hitTab [numAttempts];
	logic btnTab [numAttempts];
	int attemptCycle = 0;
	int attemptNum = 0;
	logic ledExp;

	minerTop UUT (
		.clk              (clk),
		.rst              (rst),
		.resetButton      (resetButton),
		.blockHeader      (blockHeader),
		.nonce            (nonce),
		.difficulty       (difficulty),
		.hashSuccess      (hashSuccess),
		.ledControl       (ledControl),
		.satisfactoryHash (satisfactoryHash)
	);

	always #(clockPeriod / 2) clk = ~clk;

	// Mirrors the attempt position, so cycle n is the state seen at its falling edge.
	always @(posedge clk) begin
		if (rst) begin
			attemptCycle <= 0;
			attemptNum <= 0;
		end else if (attemptCycle == attemptCycles - 1) begin
			attemptCycle <= 0;
			attemptNum <= attemptNum + 1;
		end else begin
			attemptCycle <= attemptCycle + 1;
		end
	end

	// ----------------------------------------------------------------------
	// Reference SHA-256
	// ----------------------------------------------------------------------

	function automatic word32 rotRight(word32 x, int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic digest256 compress(digest256 chain, block512 blk);
		word32 w [0:63];
		word32 v [0:7];
		word32 t1;
		word32 t2;
		digest256 result;
		for (int i = 0; i < 64; i++) begin
			if (i < 16)
				w[i] = blk[511 - 32*i -: 32];
			else
				w[i] = (rotRight(w[i-2], 17) ^ rotRight(w[i-2], 19) ^ (w[i-2] >> 10)) + w[i-7]
					+ (rotRight(w[i-15], 7) ^ rotRight(w[i-15], 18) ^ (w[i-15] >> 3)) + w[i-16];
		end
		for (int i = 0; i < 8; i++)
			v[i] = chain[255 - 32*i -: 32];
		for (int i = 0; i < 64; i++) begin
			t1 = v[7] + (rotRight(v[4], 6) ^ rotRight(v[4], 11) ^ rotRight(v[4], 25))
				+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + refK[i] + w[i];
			t2 = (rotRight(v[0], 2) ^ rotRight(v[0], 13) ^ rotRight(v[0], 22))
				+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int j = 7; j > 0; j--)
				v[j] = v[j-1];
			v[4] = v[4] + t1; // New e from old d.
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			result[255 - 32*i -: 32] = chain[255 - 32*i -: 32] + v[i];
		return result;
	endfunction

	function automatic digest256 sha256Double(header640 hdr, word32 n);
		digest256 mid;
		digest256 first;
		mid = compress(initHash, hdr[639:128]);
		first = compress(mid, {hdr[127:32], n, 1'b1, 319'b0, 64'(`MINER_SECOND_LEN)});
		return compress(initHash, {first, 1'b1, 191'b0, 64'(`MINER_FINAL_LEN)});
	endfunction

	function automatic digest256 byteSwap(digest256 d);
		digest256 r;
		for (int i = 0; i < 32; i++)
			r[8*i +: 8] = d[255 - 8*i -: 8];
		return r;
	endfunction

	function automatic header640 randomHeader();
		header640 h;
		for (int i = 0; i < 20; i++)
			h[32*i +: 32] = $urandom();
		return h;
	endfunction

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkBit(string name, logic act, logic exp);
		if (act !== exp) begin
			$display("Error: %s expected %h, actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkDigest(string name, digest256 act, digest256 exp);
		if (act !== exp) begin
			$display("Error: %s expected %h, actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic waitCycle(int a, int c);
		while (attemptNum != a || attemptCycle != c)
			@(negedge clk);
	endtask

	task automatic applyAttempt(int a);
		blockHeader = hdrTab[a];
		nonce = nonceTab[a];
		difficulty = diffTab[a];
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------

	initial begin
		digest256 rev;
		void'($urandom(32'h4660354d));
		for (int a = 0; a < numAttempts; a++) begin
			hdrTab[a] = randomHeader();
			nonceTab[a] = $urandom();
			btnTab[a] = 1'b0;
		end
		// Genesis block header. The nonce is given as it sits in the byte stream.
		hdrTab[0] = {32'h01000000, 256'h0,
			256'h3ba3edfd7a7b12b27ac72c3e67768f617fc81bc3888a51323a9fb8aa4b1e5e4a,
			32'h29ab5f49, 32'hffff001d, 32'h0};
		nonceTab[0] = 32'h1dac2b7c;
		hdrTab[3] = hdrTab[2];
		nonceTab[3] = nonceTab[2];
		hdrTab[6] = hdrTab[5];
		hdrTab[7] = hdrTab[5];
		btnTab[4] = 1'b1;
		btnTab[8] = 1'b1;
		for (int a = 0; a < numAttempts; a++) begin
			digTab[a] = sha256Double(hdrTab[a], nonceTab[a]);
			rev = byteSwap(digTab[a]);
			case (a)
				0, 6: diffTab[a] = '1;
				1, 8: diffTab[a] = '0;
				2, 4: diffTab[a] = rev; // Equal is a miss.
				default: diffTab[a] = rev + 256'd1;
			endcase
			hitTab[a] = rev < diffTab[a];
		end
		checkDigest("sha256Double", digTab[0],
			256'h6fe28c0ab6f1b372c1a6a246ae63f74f931e8365e15a089c68d6190000000000);

		rst = 1'b1;
		resetButton = 1'b0;
		applyAttempt(0);
		repeat (resetCycles) @(negedge clk);
		rst = 1'b0;
		for (int a = 0; a < numAttempts; a++) begin
			waitCycle(a, applyCycle);
			if (a + 1 < numAttempts)
				applyAttempt(a + 1);
			if (btnTab[a]) begin
				waitCycle(a, buttonCycle);
				resetButton = 1'b1;
				@(negedge clk);
				resetButton = 1'b0;
			end
		end
	end

	// Compares every cycle from the fall of rst.
	initial begin
		ledExp = 1'b0;
		repeat (resetCycles) @(negedge clk);
		while (attemptNum < numAttempts) begin
			checkBit("ledControl", ledControl, ledExp);
			if (attemptCycle == strobeCycle && hitTab[attemptNum]) begin
				checkBit("hashSuccess", hashSuccess, 1'b1);
				checkDigest("satisfactoryHash", satisfactoryHash, digTab[attemptNum]);
				ledExp = 1'b1;
			end else begin
				checkBit("hashSuccess", hashSuccess, 1'b0);
				checkDigest("satisfactoryHash", satisfactoryHash, '0);
			end
			if (attemptCycle == buttonCycle && btnTab[attemptNum])
				ledExp = 1'b0;
			@(negedge clk);
		end
		$display("TEST OK");
		$finish;
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Simulation did not finish before the watchdog limit");
		abortRun();
	end

endmodule

/* verilog.f */
+incdir+include
rtl/minerPkg.sv
rtl/sha256Schedule.sv
rtl/sha256Core.sv
rtl/minerControl.sv
rtl/minerTop.sv
tb/minerTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = minerTb
FILELIST = verilog.f
BUILD = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
